// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l2_cache_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
l2_pkg.sv
l2_tag_store.sv
l2_lookup.sv
l2_lru.sv
l2_ctrl_fsm.sv
l2_cache_ctrl.sv
l2_checker.sv
tb_l2_cache_ctrl.sv

// File: l2_cache_ctrl.sv
`timescale 1ns/1ps

module l2_cache_ctrl (
    input  logic                clk,
    input  logic                nrst,
    input  l2_pkg::cache_addr_t req,
    input  logic                read_l1,
    input  logic                write_l1,
    input  logic                flush,
    input  logic                ready_mem,
    output logic                ready_l1,
    output logic                update,
    output logic                refill,
    output logic                read_mem,
    output logic                write_mem,
    output l2_pkg::cache_addr_t mem_addr,
    output l2_pkg::tag_t        wb_tag,
    output l2_pkg::way_t        way
);
    import l2_pkg::*;

    set_view_t set_view;
    set_ages_t ages;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_dirty;
    logic      alloc;
    logic      mark_dirty;
    logic      touch;
    logic      flush_all;

    // refill address is the request itself
    assign mem_addr = req;

    l2_tag_store u_tag_store (
        .clk        (clk),
        .nrst       (nrst),
        .index      (req.index),
        .way        (way),
        .new_tag    (req.tag),
        .alloc      (alloc),
        .mark_dirty (mark_dirty),
        .flush_all  (flush_all),
        .set_view   (set_view)
    );

    l2_lru u_lru (
        .clk   (clk),
        .nrst  (nrst),
        .index (req.index),
        .way   (way),
        .touch (touch),
        .ages  (ages)
    );

    l2_lookup u_lookup (
        .tag          (req.tag),
        .set_view     (set_view),
        .ages         (ages),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (wb_tag)
    );

    l2_ctrl_fsm u_ctrl_fsm (
        .clk          (clk),
        .nrst         (nrst),
        .read_l1      (read_l1),
        .write_l1     (write_l1),
        .flush        (flush),
        .ready_mem    (ready_mem),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .ready_l1     (ready_l1),
        .update       (update),
        .refill       (refill),
        .read_mem     (read_mem),
        .write_mem    (write_mem),
        .alloc        (alloc),
        .mark_dirty   (mark_dirty),
        .touch        (touch),
        .flush_all    (flush_all),
        .way          (way)
    );

endmodule

// File: l2_checker.sv
`timescale 1ns/1ps

module l2_checker (
    input  logic                clk,
    input  logic                nrst,
    input  l2_pkg::cache_addr_t req,
    input  logic                read_l1,
    input  logic                write_l1,
    input  logic                flush,
    input  logic                ready_l1,
    input  logic                update,
    input  logic                refill,
    input  logic                read_mem,
    input  logic                write_mem,
    input  l2_pkg::cache_addr_t mem_addr,
    input  l2_pkg::tag_t        wb_tag,
    input  l2_pkg::way_t        way,
    input  int                  test_num,
    input  l2_pkg::way_t        exp_way,
    input  logic                exp_read,
    input  logic                exp_wb,
    input  l2_pkg::tag_t        exp_wb_tag,
    output int                  n_pass,
    output int                  n_fail
);
    import l2_pkg::*;

    logic        busy;
    logic        req_write;
    cache_addr_t req_addr;
    int          cycles;
    logic        seen_read;
    logic        seen_write;
    logic        seen_refill;
    logic        read_before_wb;
    tag_t        seen_wb_tag;
    logic        addr_bad;
    cache_addr_t seen_mem_addr;
    logic        flush_open;
    int          flush_test;
    logic        stray_access;
    logic        read_mem_d;
    logic        write_mem_d;

    task automatic report_mismatch(input string what, input int got, input int expected);
        $display("[ERROR] %0t ns test %0d: %s is 0x%0h, expected 0x%0h",
                 $time, test_num, what, got, expected);
    endtask

    task automatic open_flush();
        flush_open   = 1'b1;
        flush_test   = test_num;
        stray_access = 1'b0;
    endtask

    // a flush must leave memory untouched until the next request
    task automatic close_flush();
        if (stray_access)
        begin
            $display("test %0d: memory was accessed after the flush", flush_test);
            n_fail++;
        end
        else
        begin
            $display("test %0d F: ok", flush_test);
            n_pass++;
        end
        flush_open = 1'b0;
    endtask

    task automatic note_stray_access();
        if (flush_open)
            stray_access = 1'b1;
        else
        begin
            $display("memory was accessed with no request outstanding at %0t ns", $time);
            n_fail++;
        end
    endtask

    task automatic note_mem_addr();
        if (mem_addr != req_addr)
        begin
            addr_bad      = 1'b1;
            seen_mem_addr = mem_addr;
        end
    endtask

    task automatic start_request();
        if (flush_open)
            close_flush();
        busy           = 1'b1;
        req_write      = write_l1;
        req_addr       = req;
        cycles         = 0;
        seen_read      = 1'b0;
        seen_write     = 1'b0;
        seen_refill    = 1'b0;
        read_before_wb = 1'b0;
        seen_wb_tag    = '0;
        addr_bad       = 1'b0;
        seen_mem_addr  = '0;
    endtask

    task automatic check_response();
        int errs;
        errs = 0;
        if (!busy)
        begin
            $display("test %0d: ready_l1 came with no request outstanding", test_num);
            n_fail++;
        end
        else
        begin
            if (way != exp_way)
            begin
                report_mismatch("way", int'(way), int'(exp_way));
                errs++;
            end
            if (seen_read != exp_read)
            begin
                report_mismatch("memory read", int'(seen_read), int'(exp_read));
                errs++;
            end
            if (seen_write != exp_wb)
            begin
                report_mismatch("write-back", int'(seen_write), int'(exp_wb));
                errs++;
            end
            if (exp_wb && seen_wb_tag != exp_wb_tag)
            begin
                report_mismatch("wb_tag", int'(seen_wb_tag), int'(exp_wb_tag));
                errs++;
            end
            if (exp_wb && read_before_wb)
            begin
                report_mismatch("write-back before read", 0, 1);
                errs++;
            end
            if (addr_bad)
            begin
                report_mismatch("mem_addr", int'(seen_mem_addr), int'(req_addr));
                errs++;
            end
            // every fill pulses refill ahead of ready_l1
            if (seen_refill != exp_read)
            begin
                report_mismatch("refill", int'(seen_refill), int'(exp_read));
                errs++;
            end
            if (update != req_write)
            begin
                report_mismatch("update", int'(update), int'(req_write));
                errs++;
            end
            if (!exp_read && !exp_wb && cycles != 2)
            begin
                report_mismatch("hit latency", cycles, 2);
                errs++;
            end
            $display("test %0d %s tag %05h set %02h way %0d: %s", test_num,
                     req_write ? "W" : "R", req_addr.tag, req_addr.index, way,
                     errs == 0 ? "ok" : "FAILED");
            if (errs == 0)
                n_pass++;
            else
                n_fail++;
            busy = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        if (!nrst)
        begin
            busy         = 1'b0;
            flush_open   = 1'b0;
            stray_access = 1'b0;
            n_pass       = 0;
            n_fail       = 0;
            read_mem_d   = 1'b0;
            write_mem_d  = 1'b0;
        end
        else
        begin
            if (busy)
                cycles++;
            // wb_tag still shows the victim while write_mem is up
            if (write_mem && !write_mem_d)
            begin
                if (busy)
                begin
                    seen_write  = 1'b1;
                    seen_wb_tag = wb_tag;
                    note_mem_addr();
                end
                else
                    note_stray_access();
            end
            if (read_mem && !read_mem_d)
            begin
                if (busy)
                begin
                    seen_read = 1'b1;
                    if (!seen_write)
                        read_before_wb = 1'b1;
                    note_mem_addr();
                end
                else
                    note_stray_access();
            end
            if (busy && refill)
                seen_refill = 1'b1;
            if (ready_l1)
                check_response();
            else if (flush)
                open_flush();
            else if (!busy && (read_l1 || write_l1))
                start_request();
            read_mem_d  = read_mem;
            write_mem_d = write_mem;
        end
    end

endmodule

// File: l2_ctrl_fsm.sv
`timescale 1ns/1ps

module l2_ctrl_fsm (
    input  logic         clk,
    input  logic         nrst,
    input  logic         read_l1,
    input  logic         write_l1,
    input  logic         flush,
    input  logic         ready_mem,
    input  logic         hit,
    input  logic         victim_dirty,
    input  l2_pkg::way_t hit_way,
    input  l2_pkg::way_t victim_way,
    output logic         ready_l1,
    output logic         update,
    output logic         refill,
    output logic         read_mem,
    output logic         write_mem,
    output logic         alloc,
    output logic         mark_dirty,
    output logic         touch,
    output logic         flush_all,
    output l2_pkg::way_t way
);
    import l2_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        accept;
    logic        fill_done;

    // no new request while the previous ready is still showing
    assign accept    = (state == s_idle) && !flush && (read_l1 || write_l1) && !ready_l1;
    assign fill_done = (state == s_allocate) && ready_mem;

    // storage strokes act on the edge that leaves the state
    assign flush_all  = (state == s_idle) && flush;
    assign touch      = (state == s_compare) && hit;
    assign mark_dirty = touch && write_l1;
    assign alloc      = fill_done;

    always_comb
    begin
        next_state = state;
        case (state)
            s_idle:
                if (accept)
                    next_state = s_compare;
            s_compare:
                if (hit)
                    next_state = s_idle;
                else if (victim_dirty)
                    next_state = s_write_back;
                else
                    next_state = s_allocate;
            s_write_back:
                if (ready_mem)
                    next_state = s_allocate;
            s_allocate:
                if (ready_mem)
                    next_state = s_compare;
            default:
                next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state     <= s_idle;
            ready_l1  <= 1'b0;
            update    <= 1'b0;
            refill    <= 1'b0;
            read_mem  <= 1'b0;
            write_mem <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            ready_l1  <= touch;
            update    <= mark_dirty;
            refill    <= fill_done;
            // strobes drop on the edge that samples ready_mem
            read_mem  <= (state == s_allocate) && !ready_mem;
            write_mem <= (state == s_write_back) && !ready_mem;
        end
    end

    // after a fill the victim is the way just installed
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            way <= '0;
        else if (accept || fill_done)
            way <= hit ? hit_way : victim_way;
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(read_mem && write_mem))
        else $error("read_mem and write_mem high together");

    a_ready_pulse: assert property (@(posedge clk) disable iff (!nrst)
        ready_l1 |=> !ready_l1)
        else $error("ready_l1 held for two cycles");

endmodule

// File: l2_lookup.sv
`timescale 1ns/1ps

module l2_lookup (
    input  l2_pkg::tag_t      tag,
    input  l2_pkg::set_view_t set_view,
    input  l2_pkg::set_ages_t ages,
    output logic              hit,
    output l2_pkg::way_t      hit_way,
    output l2_pkg::way_t      victim_way,
    output logic              victim_dirty,
    output l2_pkg::tag_t      victim_tag
);
    import l2_pkg::*;

    logic any_invalid;
    way_t invalid_way;
    way_t lru_way;

    // tag compare against valid ways
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++)
        begin
            if (set_view[w].valid && (set_view[w].tag == tag))
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // downward scan so the lowest invalid way is kept
    always_comb
    begin
        any_invalid = 1'b0;
        invalid_way = '0;
        lru_way     = '0;
        for (int w = num_ways - 1; w >= 0; w--)
        begin
            if (!set_view[w].valid)
            begin
                any_invalid = 1'b1;
                invalid_way = way_t'(w);
            end
            if (ages[w] == age_t'(num_ways - 1))
                lru_way = way_t'(w);
        end
    end

    // an empty way beats the oldest one
    assign victim_way   = any_invalid ? invalid_way : lru_way;
    assign victim_dirty = set_view[victim_way].valid && set_view[victim_way].dirty;
    assign victim_tag   = set_view[victim_way].tag;

endmodule

// File: l2_lru.sv
`timescale 1ns/1ps

module l2_lru (
    input  logic              clk,
    input  logic              nrst,
    input  l2_pkg::index_t    index,
    input  l2_pkg::way_t      way,
    input  logic              touch,
    output l2_pkg::set_ages_t ages
);
    import l2_pkg::*;

    set_ages_t           age_mem [num_sets];
    set_ages_t           cur_ages;
    set_ages_t           next_ages;
    logic [num_ways-1:0] age_seen;

    assign cur_ages = age_mem[index];
    assign ages     = cur_ages;

    // ways younger than the touched one age by one
    always_comb
    begin
        next_ages = cur_ages;
        for (int w = 0; w < num_ways; w++)
        begin
            if (way_t'(w) == way)
                next_ages[w] = '0;
            else if (cur_ages[w] < cur_ages[way])
                next_ages[w] = cur_ages[w] + age_t'(1);
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < num_sets; s++)
                age_mem[s] <= lru_reset_ages;
        end
        else if (touch)
        begin
            age_mem[index] <= next_ages;
        end
    end

    // one flag per age value present in the set
    always_comb
    begin
        age_seen = '0;
        for (int w = 0; w < num_ways; w++)
            age_seen[cur_ages[w]] = 1'b1;
    end

    a_ages_perm: assert property (@(posedge clk) disable iff (!nrst)
        &age_seen)
        else $error("ages of set %0d are not a permutation", index);

endmodule

// File: l2_pkg.sv
package l2_pkg;

    // cache geometry
    localparam int tag_w    = 18;
    localparam int index_w  = 8;
    localparam int way_w    = 2;
    localparam int num_ways = 4;
    localparam int num_sets = 256;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [way_w-1:0]   way_t;

    // 0 is most recently used, 3 least recently used
    typedef logic [way_w-1:0]   age_t;

    // request address, also the memory address
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } cache_addr_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } line_state_t;

    typedef line_state_t [num_ways-1:0] set_view_t;

    typedef age_t [num_ways-1:0] set_ages_t;

    typedef enum logic [1:0] {
        s_idle       = 2'b00,
        s_compare    = 2'b01,
        s_write_back = 2'b10,
        s_allocate   = 2'b11
    } ctrl_state_t;

    // way3 oldest after reset, so a fresh set fills from way 0
    localparam set_ages_t lru_reset_ages = {age_t'(3), age_t'(2), age_t'(1), age_t'(0)};

endpackage

// File: l2_stim.txt
# op tag(hex) index(hex) exp_way exp_read_mem exp_write_back exp_wb_tag(hex)
# op is R read, W write, F flush; flush lines ignore the other columns
R 00100 05 0 1 0 00000
R 00200 05 1 1 0 00000
R 00300 05 2 1 0 00000
R 00400 05 3 1 0 00000
R 00100 05 0 0 0 00000
R 00200 05 1 0 0 00000
R 00500 05 2 1 0 00000
W 00400 05 3 0 0 00000
R 00100 05 0 0 0 00000
R 00200 05 1 0 0 00000
R 00500 05 2 0 0 00000
R 00600 05 3 1 1 00400
W 00400 05 0 1 0 00000
W 00200 05 1 0 0 00000
F 00000 00 0 0 0 00000
R 00200 05 0 1 0 00000
R 00400 05 1 1 0 00000
R 00200 05 0 0 0 00000
R 00100 06 0 1 0 00000
R 00100 05 2 1 0 00000

// File: l2_tag_store.sv
`timescale 1ns/1ps

module l2_tag_store (
    input  logic              clk,
    input  logic              nrst,
    input  l2_pkg::index_t    index,
    input  l2_pkg::way_t      way,
    input  l2_pkg::tag_t      new_tag,
    input  logic              alloc,
    input  logic              mark_dirty,
    input  logic              flush_all,
    output l2_pkg::set_view_t set_view
);
    import l2_pkg::*;

    tag_t                tag_mem   [num_sets][num_ways];
    logic [num_ways-1:0] valid_mem [num_sets];
    logic [num_ways-1:0] dirty_mem [num_sets];

    // tag written on install only
    always_ff @(posedge clk)
    begin
        if (alloc)
            tag_mem[index][way] <= new_tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < num_sets; s++)
            begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end
        else if (flush_all)
        begin
            // invalidate everything, dirty data is dropped
            for (int s = 0; s < num_sets; s++)
            begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end
        else if (alloc)
        begin
            valid_mem[index][way] <= 1'b1;
            dirty_mem[index][way] <= 1'b0;
        end
        else if (mark_dirty)
        begin
            dirty_mem[index][way] <= 1'b1;
        end
    end

    // read out all four ways of the addressed set
    always_comb
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            set_view[w].tag   = tag_mem[index][w];
            set_view[w].valid = valid_mem[index][w];
            set_view[w].dirty = dirty_mem[index][w];
        end
    end

    // install comes from allocate, dirty marking from a compare hit
    a_alloc_vs_dirty: assert property (@(posedge clk) disable iff (!nrst)
        !(alloc && mark_dirty))
        else $error("alloc and mark_dirty asserted together");

endmodule

// File: tb_l2_cache_ctrl.sv
`timescale 1ns/1ps

module tb_l2_cache_ctrl;
    import l2_pkg::*;

    localparam int    reset_cycles    = 8;
    localparam int    cycles_per_test = 40;
    localparam string stim_file       = "l2_stim.txt";

    typedef struct packed {
        logic [7:0]  op;
        cache_addr_t addr;
        way_t        exp_way;
        logic        exp_read;
        logic        exp_wb;
        tag_t        exp_wb_tag;
    } stim_t;

    logic        clk;
    logic        nrst;
    cache_addr_t req;
    logic        read_l1;
    logic        write_l1;
    logic        flush;
    logic        ready_mem;
    logic        ready_l1;
    logic        update;
    logic        refill;
    logic        read_mem;
    logic        write_mem;
    cache_addr_t mem_addr;
    tag_t        wb_tag;
    way_t        way;

    int          test_num;
    way_t        exp_way;
    logic        exp_read;
    logic        exp_wb;
    tag_t        exp_wb_tag;
    int          n_pass;
    int          n_fail;
    stim_t       stim_q[$];
    int          n_tests;
    int          cycle_count;
    int          cycle_limit;

    l2_cache_ctrl uut (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .read_l1   (read_l1),
        .write_l1  (write_l1),
        .flush     (flush),
        .ready_mem (ready_mem),
        .ready_l1  (ready_l1),
        .update    (update),
        .refill    (refill),
        .read_mem  (read_mem),
        .write_mem (write_mem),
        .mem_addr  (mem_addr),
        .wb_tag    (wb_tag),
        .way       (way)
    );

    l2_checker u_checker (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .read_l1    (read_l1),
        .write_l1   (write_l1),
        .flush      (flush),
        .ready_l1   (ready_l1),
        .update     (update),
        .refill     (refill),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .mem_addr   (mem_addr),
        .wb_tag     (wb_tag),
        .way        (way),
        .test_num   (test_num),
        .exp_way    (exp_way),
        .exp_read   (exp_read),
        .exp_wb     (exp_wb),
        .exp_wb_tag (exp_wb_tag),
        .n_pass     (n_pass),
        .n_fail     (n_fail)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory model, one ready_mem pulse per strobe after 1 to 6 cycles
    initial
    begin
        int delay;
        ready_mem = 1'b0;
        void'($urandom(32'h17c7));
        forever
        begin
            @(posedge clk);
            if (read_mem || write_mem)
            begin
                delay = 1 + int'($urandom % 6);
                repeat (delay - 1) @(posedge clk);
                ready_mem <= 1'b1;
                @(posedge clk);
                ready_mem <= 1'b0;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run stopped after %0d cycles with tests still pending", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic load_stim();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        int         tag;
        int         idx;
        int         w;
        int         rd;
        int         wb;
        int         wbt;
        stim_t      e;
        fd = $fopen(stim_file, "r");
        if (fd == 0)
        begin
            $display("cannot open %s", stim_file);
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%c %h %h %d %d %d %h", op, tag, idx, w, rd, wb, wbt);
                    if (n == 7)
                    begin
                        e.op         = op;
                        e.addr.tag   = tag_t'(tag);
                        e.addr.index = index_t'(idx);
                        e.exp_way    = way_t'(w);
                        e.exp_read   = (rd != 0);
                        e.exp_wb     = (wb != 0);
                        e.exp_wb_tag = tag_t'(wbt);
                        stim_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_ready();
        do
            @(posedge clk);
        while (!ready_l1);
    endtask

    task automatic run_test(input int n);
        stim_t e;
        e = stim_q[n];
        @(posedge clk);
        test_num   <= n + 1;
        exp_way    <= e.exp_way;
        exp_read   <= e.exp_read;
        exp_wb     <= e.exp_wb;
        exp_wb_tag <= e.exp_wb_tag;
        if (e.op == "F")
        begin
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
        else
        begin
            // held until ready_l1, dropped on the same edge
            req      <= e.addr;
            read_l1  <= (e.op == "R");
            write_l1 <= (e.op == "W");
            wait_ready();
            read_l1  <= 1'b0;
            write_l1 <= 1'b0;
        end
    endtask

    initial
    begin
        cycle_limit = 0;
        nrst        = 1'b0;
        req         = '0;
        read_l1     = 1'b0;
        write_l1    = 1'b0;
        flush       = 1'b0;
        test_num    = 0;
        exp_way     = '0;
        exp_read    = 1'b0;
        exp_wb      = 1'b0;
        exp_wb_tag  = '0;
        load_stim();
        n_tests = stim_q.size();
        if (n_tests == 0)
        begin
            $display("no test vectors were read from %s", stim_file);
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            cycle_limit = n_tests * cycles_per_test + reset_cycles;
            repeat (reset_cycles) @(posedge clk);
            nrst <= 1'b1;
            @(posedge clk);
            for (int i = 0; i < n_tests; i++)
                run_test(i);
            repeat (4) @(posedge clk);
            $display("tests %0d, passed %0d, failed %0d", n_tests, n_pass, n_fail);
            if (n_fail == 0 && n_pass == n_tests)
            begin
                $display("ALL TESTS PASSED");
            end
            else
            begin
                if (n_pass + n_fail != n_tests)
                    $display("only %0d of %0d tests reported a result", n_pass + n_fail, n_tests);
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule
